/* hdl/uart_dbg_pkg.sv */
// UART debug server package with protocol byte codes, field widths and the byte type
`default_nettype none

package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0] byte_t;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol codes
  ////////////////////////////////////////////////////////////////////////////

  // Commands from the host
  localparam byte_t CMD_READ  = 8'h11;
  localparam byte_t CMD_WRITE = 8'h12;
  localparam byte_t CMD_EXEC  = 8'h13;

  // Responses to the host
  localparam byte_t CODE_ACK = 8'h06;
  localparam byte_t CODE_EOT = 8'h04;
  localparam byte_t CODE_EOC = 8'h14;

  ////////////////////////////////////////////////////////////////////////////
  // Field sizes
  ////////////////////////////////////////////////////////////////////////////

  // Address and length fields, LSB first
  localparam int unsigned FIELD_BYTES = 8;
  localparam int unsigned EXIT_BYTES  = 4;
  localparam int unsigned ENTRY_WIDTH = 64;
  // Upper length bytes are dropped
  localparam int unsigned LEN_WIDTH   = 16;

endpackage

`default_nettype wire

/* hdl/mem_port_if.sv */
// Memory access port between the debug command FSM and the byte memory
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if #(
  parameter int unsigned MEM_AW = 8
);

  // Request side, driven by the FSM
  logic                mem_en;
  logic                mem_we;
  logic [MEM_AW-1:0]   mem_addr;
  uart_dbg_pkg::byte_t mem_wdata;

  // Read data, one cycle after a read request
  uart_dbg_pkg::byte_t mem_rdata;

  modport ctrl (
    output mem_en, mem_we, mem_addr, mem_wdata,
    input  mem_rdata
  );

  modport mem (
    input  mem_en, mem_we, mem_addr, mem_wdata,
    output mem_rdata
  );

endinterface

`default_nettype wire

/* hdl/baud_timer.sv */
// Bit period counter giving one tick per UART bit, optionally half a bit first
`timescale 1ns/1ps
`default_nettype none

module baud_timer #(
  parameter int unsigned CLKS_PER_BIT = 16
) (
  input  logic clk,
  input  logic rst_i,
  input  logic run_i,
  input  logic half_i,
  output logic tick_o
);

  localparam int unsigned CW = $clog2(CLKS_PER_BIT);

  localparam logic [CW-1:0] FULL_LOAD = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LOAD = CW'(CLKS_PER_BIT / 2 - 1);

  logic [CW-1:0] cnt_q;

  // Down counter, preloaded while stopped
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q <= FULL_LOAD;
    end else if (!run_i) begin
      cnt_q <= half_i ? HALF_LOAD : FULL_LOAD;
    end else if (cnt_q == '0) begin
      cnt_q <= FULL_LOAD;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign tick_o = run_i && (cnt_q == '0);

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
// UART 8N1 receiver sampling the line at bit centers
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int unsigned CLKS_PER_BIT = 16
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_byte_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e           state_q;
  logic [2:0]          sync_q;
  logic [2:0]          bit_cnt_q;
  uart_dbg_pkg::byte_t shift_q;
  logic                rx_s;
  logic                fall;
  logic                tick;

  // Two flops for the async line, the third one for edge detection
  assign rx_s = sync_q[1];
  assign fall = sync_q[2] && !sync_q[1];

  baud_timer #(
    .CLKS_PER_BIT ( CLKS_PER_BIT )
  ) i_baud_timer (
    .clk    ( clk                  ),
    .rst_i  ( rst_i                ),
    .run_i  ( state_q != RX_IDLE   ),
    .half_i ( 1'b1                 ),
    .tick_o ( tick                 )
  );

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q    <= 3'b111;
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
    end else begin
      sync_q <= {sync_q[1:0], rx_i};
      case (state_q)
        RX_IDLE: begin
          if (fall) state_q <= RX_START;
        end
        RX_START: begin
          // Glitch check at mid start bit
          if (tick) begin
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
            bit_cnt_q <= '0;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
          end
        end
        default: begin
          if (tick) state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && tick) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  // Frames with a low stop bit are dropped
  assign rx_valid_o = (state_q == RX_STOP) && tick && rx_s;
  assign rx_byte_o  = shift_q;

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
// UART 8N1 transmitter with a ready level that drops for the whole frame
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int unsigned CLKS_PER_BIT = 16
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                tx_valid_i,
  input  uart_dbg_pkg::byte_t tx_byte_i,
  output logic                tx_ready_o,
  output logic                tx_o
);

  logic       busy_q;
  logic [3:0] bit_cnt_q;
  logic [8:0] shift_q;
  logic       tx_q;
  logic       tick;

  baud_timer #(
    .CLKS_PER_BIT ( CLKS_PER_BIT )
  ) i_baud_timer (
    .clk    ( clk    ),
    .rst_i  ( rst_i  ),
    .run_i  ( busy_q ),
    .half_i ( 1'b0   ),
    .tick_o ( tick   )
  );

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      tx_q      <= 1'b1;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        busy_q    <= 1'b1;
        bit_cnt_q <= '0;
        tx_q      <= 1'b0;  // start bit
      end
    end else if (tick) begin
      // Ten ticks: eight data, stop, then end of stop bit
      tx_q      <= shift_q[0];
      bit_cnt_q <= bit_cnt_q + 1'b1;
      if (bit_cnt_q == 4'd9) busy_q <= 1'b0;
    end
  end

  // Data then stop bit, ones shifted in from the top
  always_ff @(posedge clk) begin
    if (!busy_q && tx_valid_i) begin
      shift_q <= {1'b1, tx_byte_i};
    end else if (busy_q && tick) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign tx_ready_o = !busy_q;
  assign tx_o       = tx_q;

endmodule

`default_nettype wire

/* hdl/dbg_mem.sv */
// Single port byte memory with registered read data
`timescale 1ns/1ps
`default_nettype none

module dbg_mem #(
  parameter int unsigned MEM_AW = 8
) (
  input  logic     clk,
  mem_port_if.mem  port
);

  localparam int unsigned DEPTH = 2 ** MEM_AW;

  uart_dbg_pkg::byte_t mem_q [DEPTH];

  // Write completes at the issuing edge, read data follows one cycle later
  always_ff @(posedge clk) begin
    if (port.mem_en) begin
      if (port.mem_we) begin
        mem_q[port.mem_addr] <= port.mem_wdata;
      end else begin
        port.mem_rdata <= mem_q[port.mem_addr];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/dbg_cmd_fsm.sv */
// Debug protocol FSM for ACK challenge, memory read and write, exec and end of computation
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_fsm #(
  parameter int unsigned MEM_AW = 8
) (
  input  logic                                      clk,
  input  logic                                      rst_i,
  input  logic                                      rx_valid_i,
  input  uart_dbg_pkg::byte_t                       rx_byte_i,
  output logic                                      tx_valid_o,
  output uart_dbg_pkg::byte_t                       tx_byte_o,
  input  logic                                      tx_ready_i,
  mem_port_if.ctrl                                  mem,
  output logic                                      exec_valid_o,
  output logic [uart_dbg_pkg::ENTRY_WIDTH-1:0]      exec_addr_o,
  input  logic                                      done_i,
  input  logic [8*uart_dbg_pkg::EXIT_BYTES-1:0]     exit_code_i
);

  localparam int unsigned LEN_BYTES = uart_dbg_pkg::LEN_WIDTH / 8;
  localparam int unsigned XCW       = $clog2(uart_dbg_pkg::EXIT_BYTES + 1);

  localparam logic [3:0] EXEC_LAST = 4'(uart_dbg_pkg::FIELD_BYTES - 1);
  localparam logic [3:0] RW_LAST   = 4'(2 * uart_dbg_pkg::FIELD_BYTES - 1);
  localparam logic [3:0] LEN_FIRST = 4'(uart_dbg_pkg::FIELD_BYTES);
  localparam logic [3:0] LEN_END   = 4'(uart_dbg_pkg::FIELD_BYTES + LEN_BYTES);

  typedef enum logic [2:0] {
    S_IDLE, S_HDR, S_ACK, S_WRITE, S_RD_FETCH, S_RD_SEND, S_LAST, S_EOC
  } state_e;

  state_e                                  state_q;
  uart_dbg_pkg::byte_t                     cmd_q;
  logic [3:0]                              byte_cnt_q;
  logic [uart_dbg_pkg::ENTRY_WIDTH-1:0]    entry_q;
  logic [uart_dbg_pkg::LEN_WIDTH-1:0]      len_q;
  logic [MEM_AW-1:0]                       addr_q;
  logic [8*uart_dbg_pkg::EXIT_BYTES-1:0]   exit_q;
  logic [XCW-1:0]                          exit_cnt_q;
  logic                                    done_pend_q;
  logic                                    tx_valid_q;
  uart_dbg_pkg::byte_t                     tx_byte_q;
  logic                                    tx_accept;
  logic                                    hdr_last;
  logic                                    len_last;

  assign tx_accept = tx_valid_o && tx_ready_i;
  assign hdr_last  = (cmd_q == uart_dbg_pkg::CMD_EXEC) ? (byte_cnt_q == EXEC_LAST)
                                                        : (byte_cnt_q == RW_LAST);
  assign len_last  = (len_q == uart_dbg_pkg::LEN_WIDTH'(1));

  ////////////////////////////////////////////////////////////////////////////
  // Protocol sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= S_IDLE;
      byte_cnt_q  <= '0;
      exit_cnt_q  <= '0;
      done_pend_q <= 1'b0;
      tx_valid_q  <= 1'b0;
    end else begin
      // Exit code waits here until the FSM is idle
      if (done_i && state_q != S_EOC) begin
        exit_q      <= exit_code_i;
        done_pend_q <= 1'b1;
      end
      case (state_q)
        S_IDLE: begin
          if (rx_valid_i) begin
            if (rx_byte_i == uart_dbg_pkg::CODE_ACK) begin
              tx_valid_q <= 1'b1;
              tx_byte_q  <= uart_dbg_pkg::CODE_ACK;
              state_q    <= S_LAST;
            end else if (rx_byte_i == uart_dbg_pkg::CMD_READ ||
                         rx_byte_i == uart_dbg_pkg::CMD_WRITE ||
                         rx_byte_i == uart_dbg_pkg::CMD_EXEC) begin
              cmd_q      <= rx_byte_i;
              byte_cnt_q <= '0;
              state_q    <= S_HDR;
            end
          end else if (done_pend_q) begin
            done_pend_q <= 1'b0;
            exit_cnt_q  <= '0;
            tx_valid_q  <= 1'b1;
            tx_byte_q   <= uart_dbg_pkg::CODE_EOC;
            state_q     <= S_EOC;
          end
        end
        S_HDR: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q < LEN_FIRST) begin
              entry_q <= {rx_byte_i, entry_q[uart_dbg_pkg::ENTRY_WIDTH-1:8]};
            end else if (byte_cnt_q < LEN_END) begin
              len_q <= {rx_byte_i, len_q[uart_dbg_pkg::LEN_WIDTH-1:8]};
            end
            if (hdr_last) begin
              tx_valid_q <= 1'b1;
              tx_byte_q  <= uart_dbg_pkg::CODE_ACK;
              state_q    <= S_ACK;
            end
          end
        end
        S_ACK: begin
          if (tx_accept) begin
            tx_valid_q <= 1'b0;
            addr_q     <= entry_q[MEM_AW-1:0];
            if (cmd_q == uart_dbg_pkg::CMD_EXEC) begin
              state_q <= S_IDLE;
            end else if (len_q == '0) begin
              tx_valid_q <= 1'b1;
              tx_byte_q  <= uart_dbg_pkg::CODE_EOT;
              state_q    <= S_LAST;
            end else begin
              state_q <= (cmd_q == uart_dbg_pkg::CMD_WRITE) ? S_WRITE : S_RD_FETCH;
            end
          end
        end
        S_WRITE: begin
          if (rx_valid_i) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_last) begin
              tx_valid_q <= 1'b1;
              tx_byte_q  <= uart_dbg_pkg::CODE_EOT;
              state_q    <= S_LAST;
            end
          end
        end
        S_RD_FETCH: begin
          addr_q  <= addr_q + 1'b1;
          state_q <= S_RD_SEND;
        end
        S_RD_SEND: begin
          if (tx_accept) begin
            len_q <= len_q - 1'b1;
            if (len_last) begin
              tx_valid_q <= 1'b1;
              tx_byte_q  <= uart_dbg_pkg::CODE_EOT;
              state_q    <= S_LAST;
            end else begin
              state_q <= S_RD_FETCH;
            end
          end
        end
        S_LAST: begin
          if (tx_accept) begin
            tx_valid_q <= 1'b0;
            state_q    <= S_IDLE;
          end
        end
        default: begin
          // EOC, then the exit code LSB first
          if (tx_accept) begin
            if (exit_cnt_q == XCW'(uart_dbg_pkg::EXIT_BYTES)) begin
              tx_valid_q <= 1'b0;
              state_q    <= S_IDLE;
            end else begin
              tx_byte_q  <= exit_q[7:0];
              exit_q     <= exit_q >> 8;
              exit_cnt_q <= exit_cnt_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Read data goes straight out, held by the idle memory port
  assign tx_valid_o = tx_valid_q || (state_q == S_RD_SEND);
  assign tx_byte_o  = (state_q == S_RD_SEND) ? mem.mem_rdata : tx_byte_q;

  assign mem.mem_en    = (state_q == S_WRITE && rx_valid_i) || (state_q == S_RD_FETCH);
  assign mem.mem_we    = (state_q == S_WRITE);
  assign mem.mem_addr  = addr_q;
  assign mem.mem_wdata = rx_byte_i;

  assign exec_valid_o = (state_q == S_ACK) && tx_ready_i && (cmd_q == uart_dbg_pkg::CMD_EXEC);
  assign exec_addr_o  = entry_q;

endmodule

`default_nettype wire

/* hdl/uart_dbg_top.sv */
// UART debug server top level joining receiver, transmitter, command FSM and memory
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_top #(
  parameter int unsigned CLKS_PER_BIT = 16,
  parameter int unsigned MEM_AW       = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic                                  uart_rx_i,
  output logic                                  uart_tx_o,
  output logic                                  exec_valid_o,
  output logic [uart_dbg_pkg::ENTRY_WIDTH-1:0]  exec_addr_o,
  input  logic                                  done_i,
  input  logic [8*uart_dbg_pkg::EXIT_BYTES-1:0] exit_code_i
);

  logic                rx_valid;
  uart_dbg_pkg::byte_t rx_byte;
  logic                tx_valid;
  uart_dbg_pkg::byte_t tx_byte;
  logic                tx_ready;

  mem_port_if #(.MEM_AW(MEM_AW)) mem_port ();

  ////////////////////////////////////////////////////////////////////////////
  // Serial line
  ////////////////////////////////////////////////////////////////////////////

  uart_rx #(
    .CLKS_PER_BIT ( CLKS_PER_BIT )
  ) i_uart_rx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_tx #(
    .CLKS_PER_BIT ( CLKS_PER_BIT )
  ) i_uart_tx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .tx_valid_i ( tx_valid  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Protocol and memory
  ////////////////////////////////////////////////////////////////////////////

  dbg_cmd_fsm #(
    .MEM_AW ( MEM_AW )
  ) i_dbg_cmd_fsm (
    .clk          ( clk          ),
    .rst_i        ( rst_i        ),
    .rx_valid_i   ( rx_valid     ),
    .rx_byte_i    ( rx_byte      ),
    .tx_valid_o   ( tx_valid     ),
    .tx_byte_o    ( tx_byte      ),
    .tx_ready_i   ( tx_ready     ),
    .mem          ( mem_port     ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  ),
    .done_i       ( done_i       ),
    .exit_code_i  ( exit_code_i  )
  );

  dbg_mem #(
    .MEM_AW ( MEM_AW )
  ) i_dbg_mem (
    .clk  ( clk      ),
    .port ( mem_port )
  );

endmodule

`default_nettype wire

/* tb/uart_dbg_properties.sv */
// Bound assertions on the transmit handshake, the exec pulse and the idle transmit line
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_properties #(
  parameter int unsigned CLKS_PER_BIT = 16
) (
  input logic                clk,
  input logic                rst_i,
  input logic                tx_valid_i,
  input uart_dbg_pkg::byte_t tx_byte_i,
  input logic                tx_ready_i,
  input logic                tx_line_i,
  input logic                exec_valid_i
);

  int unsigned busy_cycles_q;

  // Cycles spent with the transmitter busy
  always_ff @(posedge clk) begin
    if (rst_i || tx_ready_i) begin
      busy_cycles_q <= '0;
    end else begin
      busy_cycles_q <= busy_cycles_q + 1;
    end
  end

  // Request held until the transmitter takes it
  assert property (@(posedge clk) disable iff (rst_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_byte_i))
    else $error("tx request changed before it was accepted");

  assert property (@(posedge clk) disable iff (rst_i) exec_valid_i |=> !exec_valid_i)
    else $error("exec_valid lasted more than one cycle");

  assert property (@(posedge clk) disable iff (rst_i) tx_ready_i |-> tx_line_i)
    else $error("tx line low while the transmitter is idle");

  // One frame is ten bit periods
  assert property (@(posedge clk) disable iff (rst_i)
    $rose(tx_ready_i) |-> busy_cycles_q == 10 * CLKS_PER_BIT)
    else $error("tx frame length differs from ten bit periods");

endmodule

bind dbg_cmd_fsm uart_dbg_properties i_fsm_properties (
  .clk          ( clk          ),
  .rst_i        ( rst_i        ),
  .tx_valid_i   ( 1'b0         ),
  .tx_byte_i    ( '0           ),
  .tx_ready_i   ( 1'b1         ),
  .tx_line_i    ( 1'b1         ),
  .exec_valid_i ( exec_valid_o )
);

bind uart_tx uart_dbg_properties #(
  .CLKS_PER_BIT ( CLKS_PER_BIT )
) i_tx_properties (
  .clk          ( clk        ),
  .rst_i        ( rst_i      ),
  .tx_valid_i   ( tx_valid_i ),
  .tx_byte_i    ( tx_byte_i  ),
  .tx_ready_i   ( tx_ready_o ),
  .tx_line_i    ( tx_o       ),
  .exec_valid_i ( 1'b0       )
);

`default_nettype wire

/* tb/tb_uart_dbg.sv */
// Testbench for the UART debug server with a host UART model and a shadow memory
`timescale 1ns/1ps
`default_nettype none

module tb_uart_dbg;

  localparam int CLKS_PER_BIT = 16;
  localparam int MEM_AW       = 8;
  localparam int MEM_SIZE     = 1 << MEM_AW;
  // Bytes on the line: ACK 2, write 39, read 51, exec 10, EOC 5
  localparam int TOTAL_BYTES     = 107;
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 10 * CLKS_PER_BIT * 4;

  logic                                  clk;
  logic                                  rst_i;
  logic                                  uart_rx_i;
  logic                                  uart_tx_o;
  logic                                  exec_valid_o;
  logic [uart_dbg_pkg::ENTRY_WIDTH-1:0]  exec_addr_o;
  logic                                  done_i;
  logic [8*uart_dbg_pkg::EXIT_BYTES-1:0] exit_code_i;

  uart_dbg_pkg::byte_t exp_q[$];
  bit                  care_q[$];
  uart_dbg_pkg::byte_t got_q[$];
  uart_dbg_pkg::byte_t wr_data_q[$];
  uart_dbg_pkg::byte_t shadow_mem [MEM_SIZE];
  bit                  shadow_valid [MEM_SIZE];
  logic [15:0]         lfsr_q = 16'd22;
  logic [63:0]         exec_addr_seen;
  int                  exec_count = 0;
  int                  got_rd = 0;
  int                  cmp_checks = 0;
  int                  cmp_errors = 0;
  int                  frame_errors = 0;
  int                  test_checks = 0;
  int                  test_errors = 0;
  int                  test_num = 0;
  int                  err_mark = 0;

  uart_dbg_top #(
    .CLKS_PER_BIT ( CLKS_PER_BIT ),
    .MEM_AW       ( MEM_AW       )
  ) i_uart_dbg_top (
    .clk          ( clk          ),
    .rst_i        ( rst_i        ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  ),
    .done_i       ( done_i       ),
    .exit_code_i  ( exit_code_i  )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random data and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic logic [63:0] random_bits(input int count);
    logic [63:0] bits;
    bits = '0;
    repeat (count) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[62:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  function automatic void expect_byte(input uart_dbg_pkg::byte_t value, input bit care);
    exp_q.push_back(value);
    care_q.push_back(care);
  endfunction

  // Reply to one command, shadow memory updated for writes
  function automatic void model_command(input uart_dbg_pkg::byte_t cmd,
                                        input logic [63:0] addr, input int len);
    logic [MEM_AW-1:0] idx;
    expect_byte(uart_dbg_pkg::CODE_ACK, 1'b1);
    if (cmd == uart_dbg_pkg::CMD_WRITE || cmd == uart_dbg_pkg::CMD_READ) begin
      for (int i = 0; i < len; i++) begin
        // Addresses wrap modulo the memory size
        idx = MEM_AW'((int'(addr[MEM_AW-1:0]) + i) % MEM_SIZE);
        if (cmd == uart_dbg_pkg::CMD_WRITE) begin
          shadow_mem[idx]   = wr_data_q[i];
          shadow_valid[idx] = 1'b1;
        end else begin
          // Never written bytes are don't care
          expect_byte(shadow_mem[idx], shadow_valid[idx]);
        end
      end
      expect_byte(uart_dbg_pkg::CODE_EOT, 1'b1);
    end
  endfunction

  function automatic void model_eoc(input logic [31:0] code);
    logic [31:0] rest;
    rest = code;
    expect_byte(uart_dbg_pkg::CODE_EOC, 1'b1);
    repeat (uart_dbg_pkg::EXIT_BYTES) begin
      expect_byte(rest[7:0], 1'b1);
      rest = rest >> 8;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Host UART
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_byte(input uart_dbg_pkg::byte_t value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    repeat (10) begin
      @(posedge clk);
      uart_rx_i <= frame[0];
      frame = frame >> 1;
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic send_field(input logic [63:0] value);
    logic [63:0] rest;
    rest = value;
    repeat (uart_dbg_pkg::FIELD_BYTES) begin
      send_byte(rest[7:0]);
      rest = rest >> 8;
    end
  endtask

  initial begin : tx_line_monitor
    uart_dbg_pkg::byte_t value;
    forever begin
      @(negedge clk);
      if (!rst_i && uart_tx_o == 1'b0) begin
        // Move to the middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        repeat (8) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          value = {uart_tx_o, value[7:1]};
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx_o !== 1'b1) begin
          $display("Stop bit low on uart_tx_o at %0t", $time);
          frame_errors++;
        end
        got_q.push_back(value);
      end
    end
  end

  always @(negedge clk) begin
    if (!rst_i && exec_valid_o) begin
      exec_count     = exec_count + 1;
      exec_addr_seen = exec_addr_o;
    end
  end

  initial begin : compare_bytes
    uart_dbg_pkg::byte_t got;
    forever begin
      @(negedge clk);
      while (got_rd < got_q.size()) begin
        got = got_q[got_rd];
        got_rd++;
        if (got_rd > exp_q.size()) begin
          $display("Unexpected byte %02h from the DUT at %0t", got, $time);
          cmp_errors++;
        end else if (care_q[got_rd-1] && got !== exp_q[got_rd-1]) begin
          $display("MISMATCH at %0t: response byte %0d is %02h, expected %02h",
                   $time, got_rd - 1, got, exp_q[got_rd-1]);
          cmp_errors++;
        end else begin
          cmp_checks++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequencing
  ////////////////////////////////////////////////////////////////////////////

  function automatic int total_errors();
    return cmp_errors + frame_errors + test_errors;
  endfunction

  task automatic wait_response();
    int limit;
    int cycles;
    limit  = (exp_q.size() - got_rd + 2) * 10 * CLKS_PER_BIT * 2;
    cycles = 0;
    while (got_rd < exp_q.size() && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (got_rd < exp_q.size()) begin
      $display("Response incomplete at %0t, %0d bytes never arrived",
               $time, exp_q.size() - got_rd);
      test_errors++;
    end
    // Quiet time to catch surplus bytes
    repeat (20 * CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic report_test(input string name);
    test_num++;
    if (total_errors() == err_mark) begin
      $display("Test %0d %s: passed", test_num, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", test_num, name,
               total_errors() - err_mark);
    end
    err_mark = total_errors();
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin : main_sequence
    logic [63:0] addr;
    logic [63:0] entry;
    logic [31:0] code;
    int          exec_before;
    rst_i       = 1'b1;
    uart_rx_i   = 1'b1;
    done_i      = 1'b0;
    exit_code_i = '0;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;

    repeat (200) begin
      @(negedge clk);
      if (uart_tx_o !== 1'b1 || exec_valid_o !== 1'b0) begin
        $display("MISMATCH at %0t: idle outputs tx=%b exec_valid=%b",
                 $time, uart_tx_o, exec_valid_o);
        test_errors++;
      end else begin
        test_checks++;
      end
    end
    report_test("idle after reset");

    model_command(uart_dbg_pkg::CODE_ACK, 64'd0, 0);
    send_byte(uart_dbg_pkg::CODE_ACK);
    wait_response();
    report_test("ACK challenge");

    // Start near the top so the write wraps
    addr = random_bits(64);
    addr[MEM_AW-1 -: 4] = 4'hF;
    repeat (20) wr_data_q.push_back(8'(random_bits(8)));
    model_command(uart_dbg_pkg::CMD_WRITE, addr, 20);
    send_byte(uart_dbg_pkg::CMD_WRITE);
    send_field(addr);
    send_field(64'd20);
    foreach (wr_data_q[i]) send_byte(wr_data_q[i]);
    wait_response();
    report_test("memory write");

    addr = addr - 64'd6;
    model_command(uart_dbg_pkg::CMD_READ, addr, 32);
    send_byte(uart_dbg_pkg::CMD_READ);
    send_field(addr);
    send_field(64'd32);
    wait_response();
    report_test("memory read");

    entry       = random_bits(64);
    exec_before = exec_count;
    model_command(uart_dbg_pkg::CMD_EXEC, entry, 0);
    send_byte(uart_dbg_pkg::CMD_EXEC);
    send_field(entry);
    wait_response();
    if (exec_count - exec_before != 1) begin
      $display("exec_valid_o pulsed %0d times for one exec command", exec_count - exec_before);
      test_errors++;
    end else if (exec_addr_seen !== entry) begin
      $display("MISMATCH at %0t: exec_addr_o is %016h, expected %016h",
               $time, exec_addr_seen, entry);
      test_errors++;
    end else begin
      test_checks++;
    end
    report_test("exec");

    code = 32'(random_bits(32));
    model_eoc(code);
    @(posedge clk);
    done_i      <= 1'b1;
    exit_code_i <= code;
    @(posedge clk);
    done_i <= 1'b0;
    wait_response();
    report_test("end of computation");

    $display("Summary: %0d checks, %0d errors", cmp_checks + test_checks, total_errors());
    if (total_errors() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hdl/uart_dbg_pkg.sv
hdl/mem_port_if.sv
hdl/baud_timer.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/dbg_mem.sv
hdl/dbg_cmd_fsm.sv
hdl/uart_dbg_top.sv
tb/uart_dbg_properties.sv
tb/tb_uart_dbg.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the UART debug server testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_uart_dbg
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -f project.f

"./$BUILD_DIR/V$TOP" | tee "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures, log in $LOG"
